// ==== coreDefs.sv ====
////////////////////////////////////////
// shared types for the RV32I core subset
// word accesses only, no CSRs or traps
////////////////////////////////////////

package coreDefs;

  localparam int xlen    = 32;
  localparam int regAdrW = 5;
  localparam logic [xlen-1:0] resetPc = '0;

  // major opcodes of the kept instructions
  localparam logic [6:0] opRType  = 7'b0110011;
  localparam logic [6:0] opIType  = 7'b0010011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;

  localparam logic [31:0] nopInstr = 32'h0000_0013; // addi x0, x0, 0

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOpT;

  ////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0]         funct7;
    logic [regAdrW-1:0] rs2;
    logic [regAdrW-1:0] rs1;
    logic [2:0]         funct3;
    logic [regAdrW-1:0] rd;
    logic [6:0]         opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0]        imm;
    logic [regAdrW-1:0] rs1;
    logic [2:0]         funct3;
    logic [regAdrW-1:0] rd;
    logic [6:0]         opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0]         immHi;
    logic [regAdrW-1:0] rs2;
    logic [regAdrW-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         immLo;
    logic [6:0]         opcode;
  } sTypeT;

  typedef struct packed {
    logic               imm12;
    logic [5:0]         imm10to5;
    logic [regAdrW-1:0] rs2;
    logic [regAdrW-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm4to1;
    logic               imm11;
    logic [6:0]         opcode;
  } bTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
  } instrT;

  ////////////////////////////////////////
  // pipeline control
  ////////////////////////////////////////
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  aluSrcImm; // second operand from immediate
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic stallF, stallD, stallE, stallM, stallW;
  } stallT;

  typedef struct packed {
    logic flushD, flushE, flushM, flushW;
  } flushT;

  typedef struct packed {
    logic [xlen-1:0] adr;
    logic [xlen-1:0] writeData;
    logic            write;
    logic            read;
  } memReqT;

endpackage

// ==== regFile.sv ====
////////////////////////////////////////
// 31 registers plus hardwired x0
// written on the falling edge
////////////////////////////////////////
`timescale 1ns/10ps

module regFile (
  input  logic                         clk,
  input  logic [coreDefs::regAdrW-1:0] rs1,
  input  logic [coreDefs::regAdrW-1:0] rs2,
  input  logic [coreDefs::regAdrW-1:0] rd,
  input  logic                         we,
  input  logic [coreDefs::xlen-1:0]    wd,
  output logic [coreDefs::xlen-1:0]    rd1,
  output logic [coreDefs::xlen-1:0]    rd2
);
  import coreDefs::*;

  logic [xlen-1:0] regs [31:1];

  // first half of the cycle, so decode sees the new value
  always_ff @(negedge clk) begin
    if (we && rd != '0) regs[rd] <= wd;
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== fetchUnit.sv ====
////////////////////////////////////////
// PC and fetch/decode register
// no prediction, redirect only from execute
////////////////////////////////////////
`timescale 1ns/10ps

module fetchUnit (
  input  logic                      clk,
  input  logic                      rst,
  input  coreDefs::stallT           stall,
  input  coreDefs::flushT           flush,
  input  logic                      branchTakenE,
  input  logic [coreDefs::xlen-1:0] branchTargetE,
  input  logic [31:0]               instrF,
  output logic [coreDefs::xlen-1:0] pcF,
  output coreDefs::instrT           instrD,
  output logic [coreDefs::xlen-1:0] pcD
);
  import coreDefs::*;

  logic [xlen-1:0] pcNextF;

  assign pcNextF = branchTakenE ? branchTargetE : pcF + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) pcF <= resetPc;
    else if (!stall.stallF) pcF <= pcNextF;
  end

  // fetch/decode register, flushed slot becomes a nop
  always_ff @(posedge clk) begin
    if (rst || flush.flushD) begin
      instrD <= nopInstr;
      pcD    <= '0;
    end else if (!stall.stallD) begin
      instrD <= instrF;
      pcD    <= pcF;
    end
  end

  aPcAligned: assert property (@(posedge clk) disable iff (rst) pcF[1:0] == 2'b00)
    else $error("pcF not word aligned: %h", pcF);

endmodule

// ==== controller.sv ====
////////////////////////////////////////
// main decoder and control pipeline
// unsupported encodings decode to a bubble
////////////////////////////////////////
`timescale 1ns/10ps

module controller (
  input  logic            clk,
  input  logic            rst,
  input  coreDefs::stallT stall,
  input  coreDefs::flushT flush,
  input  coreDefs::instrT instrD,
  output coreDefs::aluOpT aluOpE,
  output logic            aluSrcImmE,
  output logic            branchE,
  output logic            memReadE,
  output logic            memWriteM,
  output logic            memReadM,
  output logic            regWriteM,
  output logic            regWriteW
);
  import coreDefs::*;

  ctrlT ctrlD, ctrlE, ctrlM;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  always_comb begin
    ctrlD = '0; // bubble unless recognised
    case (instrD.r.opcode)
      opRType: begin
        ctrlD.regWrite = 1'b1;
        case ({instrD.r.funct7, instrD.r.funct3})
          {7'h00, 3'b000}: ctrlD.aluOp = aluAdd;
          {7'h20, 3'b000}: ctrlD.aluOp = aluSub;
          {7'h00, 3'b111}: ctrlD.aluOp = aluAnd;
          {7'h00, 3'b110}: ctrlD.aluOp = aluOr;
          {7'h00, 3'b100}: ctrlD.aluOp = aluXor;
          {7'h00, 3'b010}: ctrlD.aluOp = aluSlt;
          default:         ctrlD = '0;
        endcase
      end
      opIType: if (instrD.i.funct3 == 3'b000) begin // addi only
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
      end
      opLoad: if (instrD.i.funct3 == 3'b010) begin // lw
        ctrlD.regWrite  = 1'b1;
        ctrlD.memRead   = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
      end
      opStore: if (instrD.i.funct3 == 3'b010) begin // sw
        ctrlD.memWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
      end
      opBranch: if (instrD.i.funct3 == 3'b000) begin // beq
        ctrlD.branch = 1'b1;
        ctrlD.aluOp  = aluSub;
      end
      default: ctrlD = '0;
    endcase
  end

  ////////////////////////////////////////
  // control pipeline registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush.flushE) ctrlE <= '0;
    else if (!stall.stallE)  ctrlE <= ctrlD;
    if (rst || flush.flushM) ctrlM <= '0;
    else if (!stall.stallM)  ctrlM <= ctrlE;
    if (rst || flush.flushW) regWriteW <= 1'b0;
    else if (!stall.stallW)  regWriteW <= ctrlM.regWrite;
  end

  assign aluOpE     = ctrlE.aluOp;
  assign aluSrcImmE = ctrlE.aluSrcImm;
  assign branchE    = ctrlE.branch;
  assign memReadE   = ctrlE.memRead;
  assign memReadM   = ctrlM.memRead;
  assign memWriteM  = ctrlM.memWrite;
  assign regWriteM  = ctrlM.regWrite;

  // a held stage must not be cleared in the same cycle
  aStallFlush: assert property (@(posedge clk) disable iff (rst)
    !(stall.stallE && flush.flushE) && !(stall.stallM && flush.flushM)
    && !(stall.stallW && flush.flushW))
    else $error("stage stalled and flushed at once");

endmodule

// ==== datapath.sv ====
////////////////////////////////////////
// integer datapath, execute through writeback
// forwarding from memory then writeback, beq resolved in execute
////////////////////////////////////////
`timescale 1ns/10ps

module datapath (
  input  logic                         clk,
  input  logic                         rst,
  input  coreDefs::stallT              stall,
  input  coreDefs::flushT              flush,
  input  coreDefs::instrT              instrD,
  input  logic [coreDefs::xlen-1:0]    pcD,
  input  coreDefs::aluOpT              aluOpE,
  input  logic                         aluSrcImmE,
  input  logic                         branchE,
  input  logic                         memReadM,
  input  logic                         memWriteM,
  input  logic                         regWriteM,
  input  logic                         regWriteW,
  output logic [coreDefs::regAdrW-1:0] rs1D,
  output logic [coreDefs::regAdrW-1:0] rs2D,
  output logic [coreDefs::regAdrW-1:0] rdE,
  output logic                         branchTakenE,
  output logic [coreDefs::xlen-1:0]    branchTargetE,
  output coreDefs::memReqT             dataReq,
  input  logic [coreDefs::xlen-1:0]    readData
);
  import coreDefs::*;

  logic [regAdrW-1:0] rdD, rs1E, rs2E, rdM, rdW;
  logic [xlen-1:0]    rd1D, rd2D, immD;
  logic [xlen-1:0]    rd1E, rd2E, immE, pcE;
  logic [xlen-1:0]    srcAE, fwdBE, srcBE, aluResultE;
  logic [xlen-1:0]    aluResultM, writeDataM, resultW;

  // picks the newest in-flight value of a source register
  function automatic logic [xlen-1:0] forwardOp(input logic [regAdrW-1:0] src,
                                                 input logic [xlen-1:0] regVal);
    if (regWriteM && rdM != '0 && rdM == src) return aluResultM;
    else if (regWriteW && rdW != '0 && rdW == src) return resultW;
    else return regVal;
  endfunction

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  assign rs1D = instrD.i.rs1;
  assign rs2D = instrD.s.rs2;
  assign rdD  = instrD.i.rd;

  regFile rf (.clk, .rs1(rs1D), .rs2(rs2D), .rd(rdW), .we(regWriteW), .wd(resultW),
    .rd1(rd1D), .rd2(rd2D));

  always_comb begin
    case (instrD.i.opcode)
      opStore:  immD = {{20{instrD.s.immHi[6]}}, instrD.s.immHi, instrD.s.immLo};
      opBranch: immD = {{19{instrD.b.imm12}}, instrD.b.imm12, instrD.b.imm11,
                        instrD.b.imm10to5, instrD.b.imm4to1, 1'b0};
      default:  immD = {{20{instrD.i.imm[11]}}, instrD.i.imm};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || flush.flushE) begin
      rs1E <= '0;
      rs2E <= '0;
      rdE  <= '0;
    end else if (!stall.stallE) begin
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE  <= rdD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall.stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= immD;
      pcE  <= pcD;
    end
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////
  always_comb begin
    srcAE = forwardOp(rs1E, rd1E);
    fwdBE = forwardOp(rs2E, rd2E);
  end

  assign srcBE = aluSrcImmE ? immE : fwdBE;

  always_comb begin
    case (aluOpE)
      aluSub:  aluResultE = srcAE - srcBE;
      aluAnd:  aluResultE = srcAE & srcBE;
      aluOr:   aluResultE = srcAE | srcBE;
      aluXor:  aluResultE = srcAE ^ srcBE;
      aluSlt:  aluResultE = {{(xlen-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
      default: aluResultE = srcAE + srcBE;
    endcase
  end

  assign branchTakenE  = branchE && (srcAE == fwdBE);
  assign branchTargetE = pcE + immE; // immE holds the B immediate for beq

  ////////////////////////////////////////
  // memory and writeback
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush.flushM) rdM <= '0;
    else if (!stall.stallM) rdM <= rdE;
    if (!stall.stallM) begin
      aluResultM <= aluResultE;
      writeDataM <= fwdBE;
    end
  end

  assign dataReq.adr       = aluResultM;
  assign dataReq.writeData = writeDataM;
  assign dataReq.write     = memWriteM;
  assign dataReq.read      = memReadM;

  always_ff @(posedge clk) begin
    if (rst || flush.flushW) rdW <= '0;
    else if (!stall.stallW) rdW <= rdM;
    if (!stall.stallW) resultW <= memReadM ? readData : aluResultM; // load data captured here
  end

endmodule

// ==== hazardUnit.sv ====
////////////////////////////////////////
// stall and flush generation
// memory never stalls, so only decode hazards and branches
////////////////////////////////////////
`timescale 1ns/10ps

module hazardUnit (
  input  logic [coreDefs::regAdrW-1:0] rs1D,
  input  logic [coreDefs::regAdrW-1:0] rs2D,
  input  logic [coreDefs::regAdrW-1:0] rdE,
  input  logic                         memReadE,
  input  logic                         branchTakenE,
  output coreDefs::stallT              stall,
  output coreDefs::flushT              flush
);
  import coreDefs::*;

  logic loadUseD;

  // load in execute feeding the instruction in decode
  assign loadUseD = memReadE && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));

  always_comb begin
    stall = '0;
    flush = '0;
    if (branchTakenE) begin // drop the two younger instructions
      flush.flushD = 1'b1;
      flush.flushE = 1'b1;
    end else if (loadUseD) begin
      stall.stallF = 1'b1;
      stall.stallD = 1'b1;
      flush.flushE = 1'b1; // bubble behind the load
    end
  end

endmodule

// ==== pipelinedCore.sv ====
////////////////////////////////////////
// five-stage RV32I subset core
// memories answer in the same cycle and never stall
////////////////////////////////////////
`timescale 1ns/10ps

module pipelinedCore (
  input  logic                       clk,
  input  logic                       rst,
  output logic [coreDefs::xlen-1:0]  pcF,
  input  logic [31:0]                instrF,
  output coreDefs::memReqT           dataReq,
  input  logic [coreDefs::xlen-1:0]  readData
);
  import coreDefs::*;

  stallT             stall;
  flushT             flush;
  instrT             instrD;
  logic [xlen-1:0]   pcD;
  logic              branchTakenE;
  logic [xlen-1:0]   branchTargetE;
  logic [regAdrW-1:0] rs1D, rs2D, rdE;

  // control bits handed to the datapath
  aluOpT aluOpE;
  logic  aluSrcImmE, branchE, memReadE;
  logic  memReadM, memWriteM, regWriteM, regWriteW;

  fetchUnit fu (.clk, .rst, .stall, .flush, .branchTakenE, .branchTargetE,
    .instrF, .pcF, .instrD, .pcD);

  controller ctl (.clk, .rst, .stall, .flush, .instrD,
    .aluOpE, .aluSrcImmE, .branchE, .memReadE,
    .memWriteM, .memReadM, .regWriteM, .regWriteW);

  datapath dp (.clk, .rst, .stall, .flush, .instrD, .pcD,
    .aluOpE, .aluSrcImmE, .branchE,
    .memReadM, .memWriteM, .regWriteM, .regWriteW,
    .rs1D, .rs2D, .rdE, .branchTakenE, .branchTargetE,
    .dataReq, .readData);

  // stalls and flushes for every stage
  hazardUnit hzu (.rs1D, .rs2D, .rdE, .memReadE, .branchTakenE, .stall, .flush);

endmodule

// ==== tbTests.svh ====
////////////////////////////////////////
// directed tests, included inside tbCore
// each builds its own encoded program
////////////////////////////////////////
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic logic [31:0] rInstr(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, opRType};
endfunction

function automatic logic [31:0] addiInstr(input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, opIType};
endfunction

function automatic logic [31:0] lwInstr(input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, 3'b010, rd, opLoad};
endfunction

function automatic logic [31:0] swInstr(input logic [4:0] rs2, rs1, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] beqInstr(input logic [4:0] rs1, rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], opBranch};
endfunction

task automatic clearTest();
  prog.delete();
  expAdr.delete();
  expData.delete();
  expReadAdr.delete();
endtask

task automatic expectStore(input logic [31:0] adr, input logic [31:0] data);
  expAdr.push_back(adr);
  expData.push_back(data);
endtask

task automatic expectLoad(input logic [31:0] adr);
  expReadAdr.push_back(adr);
endtask

// only nops, so the reset checks and no stores
task automatic testReset();
  clearTest();
  startProgram();
  runProgram("reset");
endtask

task automatic testAluChain();
  logic [11:0] immA, immB;
  logic [31:0] res [1:8];
  int k;
  clearTest();
  immA = nextImm();
  immB = nextImm();
  res[1] = {{20{immA[11]}}, immA};
  res[2] = {{20{immB[11]}}, immB};
  res[3] = res[1] + res[2];
  res[4] = res[3] - res[2];
  res[5] = res[4] & res[3];
  res[6] = res[5] | res[4];
  res[7] = res[6] ^ res[5];
  res[8] = ($signed(res[7]) < $signed(res[6])) ? 32'd1 : 32'd0;
  prog.push_back(addiInstr(5'd1, 5'd0, immA));
  prog.push_back(addiInstr(5'd2, 5'd0, immB));
  // each op reads the one before (memory) and two before (writeback)
  prog.push_back(rInstr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
  prog.push_back(rInstr(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));
  prog.push_back(rInstr(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
  prog.push_back(rInstr(7'h00, 3'b110, 5'd6, 5'd5, 5'd4));
  prog.push_back(rInstr(7'h00, 3'b100, 5'd7, 5'd6, 5'd5));
  prog.push_back(rInstr(7'h00, 3'b010, 5'd8, 5'd7, 5'd6));
  for (k = 3; k <= 8; k++) begin
    prog.push_back(swInstr(5'(k), 5'd0, 12'(4 * (k - 3))));
    expectStore(32'(4 * (k - 3)), res[k]);
  end
  startProgram();
  runProgram("aluChain");
endtask

task automatic testLoadUse();
  logic [11:0] immC;
  logic [31:0] valC;
  clearTest();
  immC = nextImm();
  valC = {{20{immC[11]}}, immC};
  prog.push_back(addiInstr(5'd9, 5'd0, immC));
  prog.push_back(swInstr(5'd9, 5'd0, 12'd64));
  prog.push_back(lwInstr(5'd10, 5'd0, 12'd64));
  prog.push_back(rInstr(7'h00, 3'b000, 5'd11, 5'd10, 5'd9)); // needs the stall
  prog.push_back(swInstr(5'd11, 5'd0, 12'd68));
  expectStore(32'd64, valC);
  expectLoad(32'd64);
  expectStore(32'd68, valC + valC);
  startProgram();
  runProgram("loadUse");
endtask

task automatic testBranch();
  clearTest();
  prog.push_back(addiInstr(5'd12, 5'd0, 12'd5));
  prog.push_back(addiInstr(5'd13, 5'd0, 12'd5));
  prog.push_back(beqInstr(5'd12, 5'd13, 13'd12));  // taken, skips two stores
  prog.push_back(swInstr(5'd12, 5'd0, 12'd80));
  prog.push_back(swInstr(5'd13, 5'd0, 12'd84));
  prog.push_back(swInstr(5'd12, 5'd0, 12'd88));
  prog.push_back(addiInstr(5'd14, 5'd0, 12'd6));
  prog.push_back(beqInstr(5'd12, 5'd14, 13'd8));   // not taken
  prog.push_back(swInstr(5'd14, 5'd0, 12'd92));
  expectStore(32'd88, 32'd5);
  expectStore(32'd92, 32'd6);
  startProgram();
  runProgram("branch");
endtask

task automatic testZeroReg();
  clearTest();
  prog.push_back(addiInstr(5'd15, 5'd0, 12'd7));
  prog.push_back(addiInstr(5'd0, 5'd0, 12'd123));
  prog.push_back(rInstr(7'h00, 3'b000, 5'd0, 5'd15, 5'd15));
  prog.push_back(swInstr(5'd0, 5'd0, 12'd96));
  prog.push_back(rInstr(7'h00, 3'b000, 5'd16, 5'd0, 5'd15));
  prog.push_back(swInstr(5'd16, 5'd0, 12'd100));
  expectStore(32'd96, 32'd0);
  expectStore(32'd100, 32'd7);
  startProgram();
  runProgram("zeroReg");
endtask

`endif

// ==== tbCore.sv ====
////////////////////////////////////////
// directed testbench for pipelinedCore
// 256-word memories, addresses above 1 KiB alias
////////////////////////////////////////
`timescale 1ns/10ps

module tbCore;
  import coreDefs::*;

  localparam int testBudget   = 40; // cycles allowed for the stores of one test
  localparam int settleCycles = 8;  // extra cycles to catch stray stores
  localparam int numTests     = 5;
  localparam int cycleLimit   = numTests * (testBudget + settleCycles + 8) + 50;

  logic            clk = 1'b0;
  logic            rst;
  logic [xlen-1:0] pcF;
  logic [31:0]     instrF;
  memReqT          dataReq;
  logic [xlen-1:0] readData;

  logic [31:0]     imem [0:255];
  logic [xlen-1:0] dmem [0:255];
  logic [31:0]     prog [$];
  logic [xlen-1:0] storeAdr [$];
  logic [xlen-1:0] storeData [$];
  logic [xlen-1:0] readAdr [$];
  logic [xlen-1:0] expAdr [$];
  logic [xlen-1:0] expData [$];
  logic [xlen-1:0] expReadAdr [$];
  logic [31:0]     lcgState = 32'd71;
  int              cycles = 0;
  int              checks = 0;
  int              errors = 0;
  int              testErrBase = 0;

  pipelinedCore i_dut (.clk, .rst, .pcF, .instrF, .dataReq, .readData);

  always #2 clk = ~clk;

  // both memories answer combinationally
  assign instrF   = imem[pcF[9:2]];
  assign readData = dmem[dataReq.adr[9:2]];

  // stores and loads taken mid-cycle, memory-stage outputs settled by then
  always @(negedge clk) begin
    if (!rst && dataReq.write) begin
      dmem[dataReq.adr[9:2]] <= dataReq.writeData;
      storeAdr.push_back(dataReq.adr);
      storeData.push_back(dataReq.writeData);
    end
    if (!rst && dataReq.read) readAdr.push_back(dataReq.adr);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: run went past %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [11:0] nextImm();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[27:16];
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // holds reset while the memories are reloaded
  task automatic startProgram();
    int i;
    testErrBase = errors;
    @(posedge clk);
    #1 rst = 1'b1;
    for (i = 0; i < 256; i++) begin
      if (i < prog.size()) imem[i] = prog[i];
      else imem[i] = nopInstr;
      dmem[i] = {~i[15:0], i[15:0]}; // address-dependent fill
    end
    storeAdr.delete();
    storeData.delete();
    readAdr.delete();
    repeat (4) begin
      @(posedge clk);
      #1 checkValue("pcF", pcF, resetPc);
      checkValue("dataReq.write", 32'(dataReq.write), 32'd0);
      checkValue("dataReq.read", 32'(dataReq.read), 32'd0);
    end
    rst = 1'b0;
    repeat (2) begin // nothing can reach memory yet
      @(posedge clk);
      #1 checkValue("dataReq.write", 32'(dataReq.write), 32'd0);
      checkValue("dataReq.read", 32'(dataReq.read), 32'd0);
    end
    checkValue("pcF", pcF, resetPc + 32'd8); // two sequential fetches
  endtask

  task automatic runProgram(input string name);
    int waited;
    int k;
    waited = 0;
    while (storeAdr.size() < expAdr.size() && waited < testBudget) begin
      @(posedge clk);
      waited++;
    end
    repeat (settleCycles) @(posedge clk);
    #1 checks++;
    if (storeAdr.size() != expAdr.size()) begin
      errors++;
      $display("%s: saw %0d stores where %0d were expected", name, storeAdr.size(),
               expAdr.size());
    end else begin
      for (k = 0; k < expAdr.size(); k++) begin
        checkValue("dataReq.adr", storeAdr[k], expAdr[k]);
        checkValue("dataReq.writeData", storeData[k], expData[k]);
      end
    end
    checks++;
    if (readAdr.size() != expReadAdr.size()) begin
      errors++;
      $display("%s: saw %0d loads where %0d were expected", name, readAdr.size(),
               expReadAdr.size());
    end else begin
      for (k = 0; k < expReadAdr.size(); k++) begin
        checkValue("dataReq.adr", readAdr[k], expReadAdr[k]);
      end
    end
    $display("test %s finished with %0d errors", name, errors - testErrBase);
  endtask

  `include "tbTests.svh"

  initial begin
    int i;
    rst = 1'b1;
    for (i = 0; i < 256; i++) begin
      imem[i] = nopInstr;
      dmem[i] = '0;
    end
    testReset();
    testAluChain();
    testLoadUse();
    testBranch();
    testZeroReg();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
coreDefs.sv
regFile.sv
fetchUnit.sv
controller.sv
datapath.sv
hazardUnit.sv
pipelinedCore.sv
tbCore.sv

// ==== run.sh ====
#!/bin/bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tbCore -o tbCoreSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tbCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
exit 1
